// ==== verilog/cpuPkg.sv ====
package cpuPkg;

    // Datapath widths
    localparam int XLEN       = 32;  // Data and address width
    localparam int REG_ADDR_W = 5;   // Register index
    localparam int ALU_OP_W   = 3;   // ALU operation code

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;  // add sub and or slt
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;  // addi
    localparam logic [6:0] OP_LOAD   = 7'b0000011;  // lw
    localparam logic [6:0] OP_STORE  = 7'b0100011;  // sw
    localparam logic [6:0] OP_BRANCH = 7'b1100011;  // beq

    // R-type funct3 values, sub shares 000 with add and differs in bit 30
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // ALU operation codes
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd4;  // Signed compare

    // One instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;   // Bit 5 is inst[30]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;     // Sign bit at inst[31]
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] immHi;    // imm[11:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;    // imm[4:0]
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10To5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4To1;
            logic       imm11;    // Sits where rd[0] would be
            logic [6:0] opcode;
        } bType;
    } instWord_u;

endpackage

// ==== verilog/pcUnit.sv ====
`timescale 1ns/10ps

module pcUnit import cpuPkg::*; (
    input  logic            CLK,
    input  logic            rstN,
    input  logic            branch,    // beq in flight
    input  logic            zero,      // Operands compared equal
    input  logic [XLEN-1:0] immValue,  // Byte offset for branches
    output logic [XLEN-1:0] pc
);

    logic [XLEN-1:0] pcPlus4;      // Sequential successor
    logic [XLEN-1:0] branchTarget; // pc relative target
    logic            takeBranch;
    logic [XLEN-1:0] nextPc;

    assign pcPlus4      = pc + XLEN'(4);
    assign branchTarget = pc + immValue;
    assign takeBranch   = branch & zero;  // Equal operands under beq
    assign nextPc       = takeBranch ? branchTarget : pcPlus4;

    // PC register, held at address 0 through reset
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // Branch offsets from the decoder keep bit 1 clear only if the
    // program is legal, so misalignment shows up here first
    pcAligned: assert property (
        @(posedge CLK) disable iff (!rstN)
        pc[1:0] == 2'b00
    ) else $error("pc 0x%08h is not word aligned", pc);

endmodule

// ==== verilog/instMem.sv ====
`timescale 1ns/10ps

module instMem import cpuPkg::*; #(
    parameter int IMEM_DEPTH = 64  // Words, power of two
) (
    input  logic            CLK,
    input  logic [XLEN-1:0] pc,      // Byte address of fetch
    input  logic            wrEn,    // Program load strobe
    input  logic [XLEN-1:0] wrAddr,  // Byte address of loaded word
    input  logic [XLEN-1:0] wrData,
    output logic [XLEN-1:0] inst
);

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    logic [XLEN-1:0] mem [IMEM_DEPTH];

    // Fetch uses the word index, byte offset dropped
    assign inst = mem[pc[IDX_W+1:2]];

    always_ff @(posedge CLK) begin
        if (wrEn) begin
            mem[wrAddr[IDX_W+1:2]] <= wrData;
        end
    end

    // A load beyond the array would silently alias onto low words
    loadInRange: assert property (
        @(posedge CLK) wrEn |-> (wrAddr[1:0] == 2'b00) && (wrAddr[XLEN-1:2] < IMEM_DEPTH)
    ) else $error("program load address 0x%08h outside instruction memory", wrAddr);

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/10ps

module regFile import cpuPkg::*; (
    input  logic                  CLK,
    input  logic                  rstN,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic [REG_ADDR_W-1:0] rd,        // Write index
    input  logic                  writeEn,
    input  logic [XLEN-1:0]       writeData,
    output logic [XLEN-1:0]       rdData1,
    output logic [XLEN-1:0]       rdData2
);

    // Entry 0 is cleared in reset and never written afterwards
    logic [XLEN-1:0] regs [32];

    // Combinational reads, old value until the write edge
    assign rdData1 = regs[rs1];
    assign rdData2 = regs[rs2];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;  // Whole file starts at zero
            end
        end else if (writeEn && (rd != '0)) begin
            regs[rd] <= writeData;  // Writes to x0 dropped
        end
    end

    // The write guard must keep x0 at zero on every edge
    x0StaysZero: assert property (
        @(posedge CLK) disable iff (!rstN)
        regs[0] == '0
    ) else $error("x0 holds 0x%08h instead of zero", regs[0]);

endmodule

// ==== verilog/decodeUnit.sv ====
`timescale 1ns/10ps

module decodeUnit import cpuPkg::*; (
    input  logic                  rstN,
    input  instWord_u             inst,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [REG_ADDR_W-1:0] rd,
    output logic [XLEN-1:0]       immValue,
    output logic                  aluSrc,     // 1 selects immValue as operand B
    output logic [ALU_OP_W-1:0]   aluOp,
    output logic                  memWrite,
    output logic                  memToReg,   // 1 writes back loaded data
    output logic                  regWrite,
    output logic                  branch
);

    logic [XLEN-1:0] immI;        // addi and lw
    logic [XLEN-1:0] immS;        // sw
    logic [XLEN-1:0] immB;        // beq, already a byte offset
    logic            regWriteDec; // Before reset gating
    logic            memWriteDec;

    // Register fields sit in the same place in every format
    assign rs1 = inst.rType.rs1;
    assign rs2 = inst.rType.rs2;
    assign rd  = inst.rType.rd;

    // Sign extension per format
    assign immI = {{(XLEN-12){inst.iType.imm[11]}}, inst.iType.imm};
    assign immS = {{(XLEN-12){inst.sType.immHi[6]}}, inst.sType.immHi, inst.sType.immLo};
    assign immB = {{(XLEN-13){inst.bType.imm12}}, inst.bType.imm12, inst.bType.imm11,
                   inst.bType.imm10To5, inst.bType.imm4To1, 1'b0};  // Scaled by 2

    always_comb begin
        // No-op unless the opcode says otherwise
        immValue    = '0;
        aluSrc      = 1'b0;
        aluOp       = ALU_ADD;
        memToReg    = 1'b0;
        branch      = 1'b0;
        regWriteDec = 1'b0;
        memWriteDec = 1'b0;
        case (inst.rType.opcode)
            OP_RTYPE: begin
                regWriteDec = 1'b1;
                case (inst.rType.funct3)
                    F3_ADD_SUB: aluOp = inst.rType.funct7[5] ? ALU_SUB : ALU_ADD;  // inst[30]
                    F3_SLT:     aluOp = ALU_SLT;
                    F3_OR:      aluOp = ALU_OR;
                    F3_AND:     aluOp = ALU_AND;
                    default:    regWriteDec = 1'b0;  // Shifts, xor etc. not supported
                endcase
            end
            OP_ITYPE: begin  // addi
                immValue    = immI;
                aluSrc      = 1'b1;
                regWriteDec = 1'b1;
            end
            OP_LOAD: begin  // lw, address = rs1 + imm
                immValue    = immI;
                aluSrc      = 1'b1;
                memToReg    = 1'b1;
                regWriteDec = 1'b1;
            end
            OP_STORE: begin  // sw
                immValue    = immS;
                aluSrc      = 1'b1;
                memWriteDec = 1'b1;
            end
            OP_BRANCH: begin  // beq, equality through the zero flag
                immValue = immB;
                aluOp    = ALU_SUB;
                branch   = 1'b1;
            end
            default: ;  // Unknown opcode, pc just advances
        endcase
    end

    // Reset blocks both write strobes
    assign regWrite = rstN & regWriteDec;
    assign memWrite = rstN & memWriteDec;

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/10ps

module alu import cpuPkg::*; (
    input  logic [XLEN-1:0]     operandA,   // rs1
    input  logic [XLEN-1:0]     operandB,   // rs2 or immediate
    input  logic [ALU_OP_W-1:0] aluOp,
    output logic [XLEN-1:0]     aluResult,
    output logic                zero
);

    logic lessThan;  // Signed a < b

    assign lessThan = $signed(operandA) < $signed(operandB);

    always_comb begin
        case (aluOp)
            ALU_ADD: aluResult = operandA + operandB;
            ALU_SUB: aluResult = operandA - operandB;
            ALU_AND: aluResult = operandA & operandB;
            ALU_OR:  aluResult = operandA | operandB;
            ALU_SLT: aluResult = {{(XLEN-1){1'b0}}, lessThan};
            default: aluResult = '0;
        endcase
    end

    // beq relies on this after a subtract
    assign zero = (aluResult == '0);

    // Only the decoder drives aluOp, and it never leaves the defined set
    always_comb begin
        aluOpKnown: assert (aluOp inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT})
            else $error("undefined ALU operation %0d", aluOp);
    end

endmodule

// ==== verilog/dataMem.sv ====
`timescale 1ns/10ps

module dataMem import cpuPkg::*; #(
    parameter int DMEM_DEPTH = 64  // Words, power of two
) (
    input  logic            CLK,
    input  logic [XLEN-1:0] addr,       // Byte address from the ALU
    input  logic            writeEn,
    input  logic [XLEN-1:0] writeData,  // rs2 of a sw
    output logic [XLEN-1:0] readData
);

    localparam int IDX_W = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0] mem [DMEM_DEPTH];
    logic [IDX_W-1:0] wordIdx;  // Byte offset stripped

    assign wordIdx = addr[IDX_W+1:2];

    // Read is combinational, a same-cycle sw is not forwarded
    assign readData = mem[wordIdx];

    always_ff @(posedge CLK) begin
        if (writeEn) begin
            mem[wordIdx] <= writeData;
        end
    end

    // Word accesses only, and no aliasing past the top of the array
    storeLegal: assert property (
        @(posedge CLK)
        writeEn |-> (addr[1:0] == 2'b00) && (addr[XLEN-1:2] < DMEM_DEPTH)
    ) else $error("store to 0x%08h misaligned or outside data memory", addr);

endmodule

// ==== verilog/singleCpu.sv ====
`timescale 1ns/10ps

module singleCpu import cpuPkg::*; #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                  CLK,
    input  logic                  rstN,
    input  logic                  imemWrEn,        // Program load, only in reset
    input  logic [XLEN-1:0]       imemWrAddr,
    input  logic [XLEN-1:0]       imemWrData,
    output logic [XLEN-1:0]       pc,
    output logic [XLEN-1:0]       inst,
    output logic                  commitRegWrite,  // Retiring instruction writes rd
    output logic [REG_ADDR_W-1:0] commitRd,
    output logic [XLEN-1:0]       commitData,
    output logic                  commitMemWrite,
    output logic [XLEN-1:0]       commitMemAddr,
    output logic [XLEN-1:0]       commitMemData
);

    logic [REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [XLEN-1:0]       immValue;
    logic                  aluSrc, memWrite, memToReg, regWrite, branch;
    logic [ALU_OP_W-1:0]   aluOp;
    logic [XLEN-1:0]       rdData1, rdData2;
    logic [XLEN-1:0]       operandB;   // Register or immediate
    logic [XLEN-1:0]       aluResult;  // Also the memory address
    logic                  zero;
    logic [XLEN-1:0]       loadData;
    logic [XLEN-1:0]       writeData;  // Write-back value

    pcUnit u_pcUnit (.CLK(CLK), .rstN(rstN), .branch(branch), .zero(zero),
                     .immValue(immValue), .pc(pc));

    instMem #(.IMEM_DEPTH(IMEM_DEPTH)) u_instMem (
        .CLK(CLK), .pc(pc), .wrEn(imemWrEn), .wrAddr(imemWrAddr),
        .wrData(imemWrData), .inst(inst));

    decodeUnit u_decodeUnit (
        .rstN(rstN), .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .immValue(immValue),
        .aluSrc(aluSrc), .aluOp(aluOp), .memWrite(memWrite), .memToReg(memToReg),
        .regWrite(regWrite), .branch(branch));

    regFile u_regFile (
        .CLK(CLK), .rstN(rstN), .rs1(rs1), .rs2(rs2), .rd(rd), .writeEn(regWrite),
        .writeData(writeData), .rdData1(rdData1), .rdData2(rdData2));

    assign operandB = aluSrc ? immValue : rdData2;

    alu u_alu (.operandA(rdData1), .operandB(operandB), .aluOp(aluOp),
               .aluResult(aluResult), .zero(zero));

    dataMem #(.DMEM_DEPTH(DMEM_DEPTH)) u_dataMem (
        .CLK(CLK), .addr(aluResult), .writeEn(memWrite), .writeData(rdData2),
        .readData(loadData));

    assign writeData = memToReg ? loadData : aluResult;  // lw or ALU result

    // Commit view of the instruction retiring this cycle
    assign commitRegWrite = regWrite;
    assign commitRd       = rd;
    assign commitData     = writeData;
    assign commitMemWrite = memWrite;
    assign commitMemAddr  = aluResult;
    assign commitMemData  = rdData2;

endmodule

// ==== verif/singleCpuTb.sv ====
`timescale 1ns/10ps

module singleCpuTb import cpuPkg::*; ();

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 4;
    localparam int MAX_PROG        = 16;  // Longest program and longest run per test
    localparam int NUM_TESTS       = 5;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (RESET_CYCLES + 2 + 2 * MAX_PROG) + 20;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;  // inst[30] set

    logic                  CLK = 1'b0;
    logic                  rstN, imemWrEn;
    logic [XLEN-1:0]       imemWrAddr, imemWrData;
    logic [XLEN-1:0]       pc, inst, commitData, commitMemAddr, commitMemData;
    logic                  commitRegWrite, commitMemWrite;
    logic [REG_ADDR_W-1:0] commitRd;

    // Reference state of the ISA model
    logic [XLEN-1:0] modelRegs [32];
    logic [XLEN-1:0] modelMem [logic [XLEN-1:0]];  // Stored words only
    logic [XLEN-1:0] modelPc;
    instWord_u       progQ [$];                    // Program of the running test
    string           testName;
    integer          seed = 9;
    int              errorCount = 0;
    int              checkCount = 0;

    singleCpu #(.IMEM_DEPTH(64), .DMEM_DEPTH(64)) u_singleCpu (
        .CLK(CLK), .rstN(rstN), .imemWrEn(imemWrEn), .imemWrAddr(imemWrAddr),
        .imemWrData(imemWrData), .pc(pc), .inst(inst), .commitRegWrite(commitRegWrite),
        .commitRd(commitRd), .commitData(commitData), .commitMemWrite(commitMemWrite),
        .commitMemAddr(commitMemAddr), .commitMemData(commitMemData));

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // Watchdog, sized from the test lengths
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    task automatic checkWord(string what, logic [XLEN-1:0] expected, logic [XLEN-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error [%s] %s: expected 0x%08h, actual 0x%08h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic checkRegIdx(string what, logic [REG_ADDR_W-1:0] expected,
                               logic [REG_ADDR_W-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error [%s] %s: expected x%0d, actual x%0d",
                     testName, what, expected, actual);
        end
    endtask

    task automatic checkBit(string what, logic expected, logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error [%s] %s: expected %b, actual %b", testName, what, expected, actual);
        end
    endtask

    // Instruction encoders, one per format
    function automatic instWord_u rTypeInst(logic [6:0] funct7, logic [2:0] funct3,
                                            logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        instWord_u w;
        w = '0;
        w.rType.funct7 = funct7;
        w.rType.rs2    = rs2;
        w.rType.rs1    = rs1;
        w.rType.funct3 = funct3;
        w.rType.rd     = rd;
        w.rType.opcode = OP_RTYPE;
        return w;
    endfunction

    function automatic instWord_u iTypeInst(logic [6:0] opcode, logic [4:0] rd,
                                            logic [4:0] rs1, logic [11:0] imm);
        instWord_u w;
        w = '0;
        w.iType.imm    = imm;
        w.iType.rs1    = rs1;
        w.iType.funct3 = (opcode == OP_LOAD) ? 3'b010 : 3'b000;  // lw or addi
        w.iType.rd     = rd;
        w.iType.opcode = opcode;
        return w;
    endfunction

    function automatic instWord_u sTypeInst(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        instWord_u w;
        w = '0;
        w.sType.immHi  = imm[11:5];
        w.sType.rs2    = rs2;
        w.sType.rs1    = rs1;
        w.sType.funct3 = 3'b010;  // sw
        w.sType.immLo  = imm[4:0];
        w.sType.opcode = OP_STORE;
        return w;
    endfunction

    function automatic instWord_u bTypeInst(logic [4:0] rs1, logic [4:0] rs2,
                                            logic [12:0] offset);
        instWord_u w;
        w = '0;
        w.bType.imm12    = offset[12];
        w.bType.imm10To5 = offset[10:5];
        w.bType.rs2      = rs2;
        w.bType.rs1      = rs1;
        w.bType.imm4To1  = offset[4:1];  // Bit 0 implied zero
        w.bType.imm11    = offset[11];
        w.bType.opcode   = OP_BRANCH;    // funct3 000 is beq
        return w;
    endfunction

    task automatic holdReset(int cycles);
        rstN = 1'b0;  // Asynchronous, pc drops to 0 at once
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        modelPc = '0;
        repeat (cycles) begin
            @(negedge CLK);
            checkWord("pc in reset", '0, pc);
            checkBit("regWrite in reset", 1'b0, commitRegWrite);
            checkBit("memWrite in reset", 1'b0, commitMemWrite);
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < progQ.size(); i++) begin
            imemWrEn   = 1'b1;
            imemWrAddr = XLEN'(i * 4);
            imemWrData = progQ[i];
            @(posedge CLK);  // Word lands on this edge
            #1;
            checkBit("regWrite in load", 1'b0, commitRegWrite);  // New word 0 decoded in reset
            checkBit("memWrite in load", 1'b0, commitMemWrite);
        end
        imemWrEn = 1'b0;
    endtask

    // Reset, load, release; first fetch follows in this cycle
    task automatic bootProgram();
        holdReset(RESET_CYCLES);
        loadProgram();
        rstN = 1'b1;
    endtask

    // One instruction: predict from the ISA rules, check mid-cycle, then retire
    task automatic stepAndCheck();
        instWord_u             w;
        logic [XLEN-1:0]       a, b, res, addr, nextPc, immI, immS, immB;
        logic                  expRegWrite, expMemWrite;
        int                    idx;
        idx = int'(modelPc >> 2);
        if (idx >= progQ.size()) begin
            errorCount++;
            $display("[%s] model pc 0x%08h ran past the end of the program", testName, modelPc);
            return;
        end
        w    = progQ[idx];
        a    = modelRegs[w.rType.rs1];
        b    = modelRegs[w.rType.rs2];
        immI = XLEN'($signed(w.iType.imm));
        immS = XLEN'($signed({w.sType.immHi, w.sType.immLo}));
        immB = XLEN'($signed({w.bType.imm12, w.bType.imm11, w.bType.imm10To5,
                              w.bType.imm4To1, 1'b0}));
        expRegWrite = 1'b0;
        expMemWrite = 1'b0;
        res         = '0;
        addr        = '0;
        nextPc      = modelPc + XLEN'(4);
        case (w.rType.opcode)
            OP_RTYPE: begin
                expRegWrite = 1'b1;
                case (w.rType.funct3)
                    F3_ADD_SUB: res = w.rType.funct7[5] ? a - b : a + b;
                    F3_SLT:     res = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
                    F3_OR:      res = a | b;
                    F3_AND:     res = a & b;
                    default:    expRegWrite = 1'b0;  // Unsupported R-type is a no-op
                endcase
            end
            OP_ITYPE: begin
                expRegWrite = 1'b1;
                res         = a + immI;
            end
            OP_LOAD: begin
                expRegWrite = 1'b1;
                addr        = a + immI;
                if (modelMem.exists(addr)) begin
                    res = modelMem[addr];
                end else begin
                    errorCount++;
                    $display("[%s] lw reads 0x%08h, which no sw wrote", testName, addr);
                end
            end
            OP_STORE: begin
                expMemWrite = 1'b1;
                addr        = a + immS;
            end
            OP_BRANCH: begin
                if (a == b) nextPc = modelPc + immB;  // Taken beq
            end
            default: ;
        endcase
        @(negedge CLK);
        checkWord("pc", modelPc, pc);
        checkWord("inst", w, inst);
        checkBit("commitRegWrite", expRegWrite, commitRegWrite);
        if (expRegWrite) begin
            checkRegIdx("commitRd", w.rType.rd, commitRd);
            checkWord("commitData", res, commitData);
        end
        checkBit("commitMemWrite", expMemWrite, commitMemWrite);
        if (expMemWrite) begin
            checkWord("commitMemAddr", addr, commitMemAddr);
            checkWord("commitMemData", b, commitMemData);
        end
        if (expRegWrite && w.rType.rd != '0) modelRegs[w.rType.rd] = res;  // x0 stays 0
        if (expMemWrite) modelMem[addr] = b;
        modelPc = nextPc;
        @(posedge CLK);
        #1;
    endtask

    task automatic testReset();
        testName = "testReset";
        progQ    = {};
        progQ.push_back(sTypeInst(5'd0, 5'd0, 12'd4));  // Store of x0 at word 1
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd1, 5'd0, 12'd5));
        progQ.push_back(sTypeInst(5'd1, 5'd0, 12'd8));
        holdReset(RESET_CYCLES);
        loadProgram();
        holdReset(2);  // Real sw at address 0 now, strobes still low
        rstN = 1'b1;
        repeat (progQ.size()) stepAndCheck();
    endtask

    task automatic testArith();
        logic [11:0] opA;
        logic [11:0] opB;
        testName = "testArith";
        opA      = 12'($random(seed));
        opB      = 12'($random(seed));
        progQ    = {};
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd1, 5'd0, opA));
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd2, 5'd0, opB));
        progQ.push_back(rTypeInst(F7_BASE, F3_ADD_SUB, 5'd3, 5'd1, 5'd2));
        progQ.push_back(rTypeInst(F7_SUB, F3_ADD_SUB, 5'd4, 5'd1, 5'd2));
        progQ.push_back(rTypeInst(F7_BASE, F3_AND, 5'd5, 5'd1, 5'd2));
        progQ.push_back(rTypeInst(F7_BASE, F3_OR, 5'd6, 5'd1, 5'd2));
        progQ.push_back(rTypeInst(F7_BASE, F3_SLT, 5'd7, 5'd1, 5'd2));
        progQ.push_back(rTypeInst(F7_BASE, F3_SLT, 5'd8, 5'd2, 5'd1));
        progQ.push_back(rTypeInst(F7_BASE, F3_ADD_SUB, 5'd0, 5'd1, 5'd2));  // Reported, dropped
        progQ.push_back(rTypeInst(F7_BASE, F3_ADD_SUB, 5'd9, 5'd0, 5'd1));  // x0 reads 0
        progQ.push_back(rTypeInst(F7_BASE, F3_OR, 5'd10, 5'd0, 5'd0));
        bootProgram();
        repeat (progQ.size()) stepAndCheck();
    endtask

    task automatic testMemory();
        testName = "testMemory";
        progQ    = {};
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd1, 5'd0, 12'($random(seed))));
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd2, 5'd0, 12'd16));   // Base address
        progQ.push_back(sTypeInst(5'd1, 5'd2, 12'd8));              // Word 24
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd3, 5'd0, 12'hFFC));  // -4
        progQ.push_back(sTypeInst(5'd3, 5'd2, 12'hFF8));            // Word 8, negative offset
        progQ.push_back(iTypeInst(OP_LOAD, 5'd4, 5'd2, 12'd8));
        progQ.push_back(iTypeInst(OP_LOAD, 5'd5, 5'd2, 12'hFF8));
        progQ.push_back(rTypeInst(F7_BASE, F3_ADD_SUB, 5'd6, 5'd4, 5'd5));
        bootProgram();
        repeat (progQ.size()) stepAndCheck();
    endtask

    task automatic testBranch();
        testName = "testBranch";
        progQ    = {};
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd1, 5'd0, 12'd7));
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd2, 5'd0, 12'd7));
        progQ.push_back(bTypeInst(5'd1, 5'd2, 13'd12));  // Taken to 20
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd3, 5'd0, 12'd1));
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd3, 5'd0, 12'd2));
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd4, 5'd0, 12'd3));
        progQ.push_back(bTypeInst(5'd1, 5'd4, 13'd8));   // 7 vs 3, falls through
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd5, 5'd0, 12'd9));
        progQ.push_back(bTypeInst(5'd0, 5'd0, 13'd8));   // Always taken
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd6, 5'd0, 12'd1));
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd6, 5'd0, 12'd5));
        bootProgram();
        repeat (8) stepAndCheck();  // Path 0,1,2,5,6,7,8,10
    endtask

    task automatic testIllegal();
        testName = "testIllegal";
        progQ    = {};
        progQ.push_back(iTypeInst(OP_ITYPE, 5'd1, 5'd0, 12'd3));
        progQ.push_back(iTypeInst(7'b0001011, 5'd1, 5'd1, 12'd1));   // custom-0 opcode
        progQ.push_back(rTypeInst(F7_BASE, 3'b100, 5'd1, 5'd1, 5'd1));  // xor, unsupported
        progQ.push_back(instWord_u'(32'h0));
        progQ.push_back(rTypeInst(F7_BASE, F3_ADD_SUB, 5'd2, 5'd1, 5'd0));  // x1 untouched
        bootProgram();
        repeat (progQ.size()) stepAndCheck();
    endtask

    initial begin
        rstN       = 1'b0;
        imemWrEn   = 1'b0;
        imemWrAddr = '0;
        imemWrData = '0;
        @(posedge CLK);
        #1;
        testReset();
        testArith();
        testMemory();
        testBranch();
        testIllegal();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/cpuPkg.sv
verilog/pcUnit.sv
verilog/instMem.sv
verilog/regFile.sv
verilog/decodeUnit.sv
verilog/alu.sv
verilog/dataMem.sv
verilog/singleCpu.sv
verif/singleCpuTb.sv

// ==== Makefile ====
TOP := singleCpuTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
